/* common/glb_pkg.sv */
// global buffer shared definitions
package glb_pkg;

    // processor side
    localparam int BANK_DATA_WIDTH = 64;
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;
    localparam int GLB_ADDR_WIDTH = 16;
    localparam int BYTE_OFFSET_WIDTH = 3;

    // configuration side
    localparam int CFG_ADDR_WIDTH = 12;
    localparam int CFG_DATA_WIDTH = 32;
    localparam int CFG_TILE_SEL_LSB = 8;
    localparam int CFG_TILE_SEL_WIDTH = 4;
    localparam int CFG_REG_SEL_LSB = 2;
    localparam int CFG_REG_SEL_WIDTH = 2;

    // per-tile register map
    localparam int CFG_REG_TILE_EN = 0;
    localparam int CFG_REG_WR_COUNT = 1;

    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0] rd_data;
        logic                       rd_data_valid;
    } rdrs_packet_t;

    typedef struct packed {
        logic                       wr_en;
        logic [BANK_STRB_WIDTH-1:0] wr_strb;
        logic [GLB_ADDR_WIDTH-1:0]  wr_addr;
        logic [BANK_DATA_WIDTH-1:0] wr_data;
        logic                       rd_en;
        logic [GLB_ADDR_WIDTH-1:0]  rd_addr;
        rdrs_packet_t               rdrs;
    } proc_packet_t;

    typedef struct packed {
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      rd_data_valid;
    } cfg_rdrs_t;

    typedef struct packed {
        logic                      wr_en;
        logic                      rd_en;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
        cfg_rdrs_t                 rdrs;
    } cfg_packet_t;

    // tile index sits above the byte offset and the bank word address
    function automatic logic [GLB_ADDR_WIDTH-1:0] proc_tile_index(
        input logic [GLB_ADDR_WIDTH-1:0] addr,
        input int                        bank_addr_width
    );
        return addr >> (BYTE_OFFSET_WIDTH + bank_addr_width);
    endfunction

    function automatic logic [CFG_TILE_SEL_WIDTH-1:0] cfg_tile_index(
        input logic [CFG_ADDR_WIDTH-1:0] addr
    );
        return addr[CFG_TILE_SEL_LSB +: CFG_TILE_SEL_WIDTH];
    endfunction

    function automatic logic [CFG_REG_SEL_WIDTH-1:0] cfg_reg_index(
        input logic [CFG_ADDR_WIDTH-1:0] addr
    );
        return addr[CFG_REG_SEL_LSB +: CFG_REG_SEL_WIDTH];
    endfunction

endpackage

/* glb_tile/glb_bank.sv */
// byte-strobed tile bank
`timescale 1ns/1ps

module glb_bank #(
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                clk,
    input  logic                                wr_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0] wr_strb,
    input  logic [BANK_ADDR_WIDTH-1:0]          wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0] wr_data,
    input  logic                                rd_en,
    input  logic [BANK_ADDR_WIDTH-1:0]          rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] rd_data
);
    import glb_pkg::*;

    localparam int NUM_WORDS = 2 ** BANK_ADDR_WIDTH;

    logic [BANK_DATA_WIDTH-1:0] mem [NUM_WORDS];

    // one strobe bit per byte lane
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // same-edge write is not seen, read returns the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    wr_addr_known_a: assert property (@(posedge clk)
        wr_en |-> !$isunknown(wr_addr));

    rd_addr_known_a: assert property (@(posedge clk)
        rd_en |-> !$isunknown(rd_addr));

endmodule

/* glb_tile/glb_tile.sv */
// global buffer tile
`timescale 1ns/1ps

module glb_tile #(
    parameter int TILE_ID = 0,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic                  reset,

    // processor chain
    input  glb_pkg::proc_packet_t proc_packet_wsti,
    output glb_pkg::proc_packet_t proc_packet_esto,
    input  glb_pkg::rdrs_packet_t proc_rdrs_esti,
    output glb_pkg::rdrs_packet_t proc_rdrs_wsto,

    // configuration chain
    input  glb_pkg::cfg_packet_t  cfg_packet_wsti,
    output glb_pkg::cfg_packet_t  cfg_packet_esto,
    input  glb_pkg::cfg_rdrs_t    cfg_rdrs_esti,
    output glb_pkg::cfg_rdrs_t    cfg_rdrs_wsto
);
    import glb_pkg::*;

    logic                       wr_owned;
    logic                       rd_owned;
    logic                       cfg_owned;
    logic                       tile_en;
    logic                       bank_wr_en;
    logic                       bank_rd_en;
    logic                       cfg_wr_en;
    logic                       cfg_rd_en;
    logic [BANK_DATA_WIDTH-1:0] bank_rd_data;
    logic [CFG_DATA_WIDTH-1:0]  cfg_rd_data;
    proc_packet_t               proc_east_q;
    cfg_packet_t                cfg_east_q;
    logic                       bank_rd_q;
    logic                       cfg_rd_q;

    // address ownership
    assign wr_owned =
        int'(proc_tile_index(proc_packet_wsti.wr_addr, BANK_ADDR_WIDTH)) == TILE_ID;
    assign rd_owned =
        int'(proc_tile_index(proc_packet_wsti.rd_addr, BANK_ADDR_WIDTH)) == TILE_ID;
    assign cfg_owned = int'(cfg_tile_index(cfg_packet_wsti.addr)) == TILE_ID;

    // a disabled tile drops its writes
    assign bank_wr_en = proc_packet_wsti.wr_en && wr_owned && tile_en;
    assign bank_rd_en = proc_packet_wsti.rd_en && rd_owned;
    assign cfg_wr_en = cfg_packet_wsti.wr_en && cfg_owned;
    assign cfg_rd_en = cfg_packet_wsti.rd_en && cfg_owned;

    glb_bank #(
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) u_bank (
        .clk     (clk),
        .wr_en   (bank_wr_en),
        .wr_strb (proc_packet_wsti.wr_strb),
        .wr_addr (proc_packet_wsti.wr_addr[BYTE_OFFSET_WIDTH +: BANK_ADDR_WIDTH]),
        .wr_data (proc_packet_wsti.wr_data),
        .rd_en   (bank_rd_en),
        .rd_addr (proc_packet_wsti.rd_addr[BYTE_OFFSET_WIDTH +: BANK_ADDR_WIDTH]),
        .rd_data (bank_rd_data)
    );

    glb_tile_cfg u_tile_cfg (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (cfg_wr_en),
        .rd_en   (cfg_rd_en),
        .reg_sel (cfg_reg_index(cfg_packet_wsti.addr)),
        .wr_data (cfg_packet_wsti.wr_data),
        .bank_wr (bank_wr_en),
        .tile_en (tile_en),
        .rd_data (cfg_rd_data)
    );

    // east stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_east_q <= '0;
            cfg_east_q <= '0;
            bank_rd_q <= 1'b0;
            cfg_rd_q <= 1'b0;
        end else begin
            proc_east_q <= proc_packet_wsti;
            cfg_east_q <= cfg_packet_wsti;
            bank_rd_q <= bank_rd_en;
            cfg_rd_q <= cfg_rd_en;
        end
    end

    // bank and register data land in the same cycle as the stage
    always_comb begin
        proc_packet_esto = proc_east_q;
        if (bank_rd_q) begin
            proc_packet_esto.rdrs.rd_data = bank_rd_data;
            proc_packet_esto.rdrs.rd_data_valid = 1'b1;
        end
    end

    always_comb begin
        cfg_packet_esto = cfg_east_q;
        if (cfg_rd_q) begin
            cfg_packet_esto.rdrs.rd_data = cfg_rd_data;
            cfg_packet_esto.rdrs.rd_data_valid = 1'b1;
        end
    end

    // west stage holds one register per tile
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_rdrs_wsto <= '0;
            cfg_rdrs_wsto <= '0;
        end else begin
            proc_rdrs_wsto <= proc_rdrs_esti;
            cfg_rdrs_wsto <= cfg_rdrs_esti;
        end
    end

    // only one tile may answer a given read
    proc_single_owner_a: assert property (@(posedge clk) disable iff (reset)
        bank_rd_en |-> !proc_packet_wsti.rdrs.rd_data_valid);

    cfg_single_owner_a: assert property (@(posedge clk) disable iff (reset)
        cfg_rd_en |-> !cfg_packet_wsti.rdrs.rd_data_valid);

endmodule

/* glb_tile/glb_tile_cfg.sv */
// tile configuration registers
`timescale 1ns/1ps

module glb_tile_cfg (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  wr_en,
    input  logic                                  rd_en,
    input  logic [glb_pkg::CFG_REG_SEL_WIDTH-1:0] reg_sel,
    input  logic [glb_pkg::CFG_DATA_WIDTH-1:0]    wr_data,
    input  logic                                  bank_wr,
    output logic                                  tile_en,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0]    rd_data
);
    import glb_pkg::*;

    logic                      sel_tile_en;
    logic                      sel_wr_count;
    logic [CFG_DATA_WIDTH-1:0] wr_count;

    assign sel_tile_en = reg_sel == CFG_REG_SEL_WIDTH'(CFG_REG_TILE_EN);
    assign sel_wr_count = reg_sel == CFG_REG_SEL_WIDTH'(CFG_REG_WR_COUNT);

    // tile enable lives in bit 0 of register 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tile_en <= 1'b1;
        end else if (wr_en && sel_tile_en) begin
            tile_en <= wr_data[0];
        end
    end

    // counts accepted bank writes and wraps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_count <= '0;
        end else if (bank_wr) begin
            wr_count <= wr_count + 1'b1;
        end
    end

    // registered so it lines up with the tile's east stage
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (sel_tile_en) begin
                rd_data <= {{(CFG_DATA_WIDTH-1){1'b0}}, tile_en};
            end else if (sel_wr_count) begin
                rd_data <= wr_count;
            end else begin
                // unmapped registers read as zero
                rd_data <= '0;
            end
        end
    end

endmodule

/* list.f */
common/glb_pkg.sv
glb_tile/glb_bank.sv
glb_tile/glb_tile_cfg.sv
glb_tile/glb_tile.sv
logic/glb_dummy_start.sv
logic/global_buffer.sv
sim/tb_global_buffer.sv

/* logic/glb_dummy_start.sv */
// global buffer entry block
`timescale 1ns/1ps

module glb_dummy_start #(
    parameter int NUM_TILES = 4,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                 clk,
    input  logic                                 reset,

    // processor port
    input  logic                                 proc_wr_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0]  proc_wr_strb,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]   proc_wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0]  proc_wr_data,
    input  logic                                 proc_rd_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]   proc_rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]  proc_rd_data,
    output logic                                 proc_rd_data_valid,

    // configuration port
    input  logic                                 cfg_wr_en,
    input  logic                                 cfg_rd_en,
    input  logic [glb_pkg::CFG_ADDR_WIDTH-1:0]   cfg_addr,
    input  logic [glb_pkg::CFG_DATA_WIDTH-1:0]   cfg_wr_data,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0]   cfg_rd_data,
    output logic                                 cfg_rd_data_valid,

    // chains
    output glb_pkg::proc_packet_t                proc_packet_esto,
    input  glb_pkg::rdrs_packet_t                proc_rdrs_wsti,
    output glb_pkg::cfg_packet_t                 cfg_packet_esto,
    input  glb_pkg::cfg_rdrs_t                   cfg_rdrs_wsti
);
    import glb_pkg::*;

    logic proc_rd_unmapped;
    logic cfg_rd_unmapped;

    // no tile will claim these, so the response is launched here already
    assign proc_rd_unmapped = proc_rd_en &&
        (int'(proc_tile_index(proc_rd_addr, BANK_ADDR_WIDTH)) >= NUM_TILES);
    assign cfg_rd_unmapped = cfg_rd_en && (int'(cfg_tile_index(cfg_addr)) >= NUM_TILES);

    // eastward packets
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_packet_esto <= '0;
            cfg_packet_esto <= '0;
        end else begin
            proc_packet_esto.wr_en <= proc_wr_en;
            proc_packet_esto.wr_strb <= proc_wr_strb;
            proc_packet_esto.wr_addr <= proc_wr_addr;
            proc_packet_esto.wr_data <= proc_wr_data;
            proc_packet_esto.rd_en <= proc_rd_en;
            proc_packet_esto.rd_addr <= proc_rd_addr;
            proc_packet_esto.rdrs.rd_data <= '0;
            proc_packet_esto.rdrs.rd_data_valid <= proc_rd_unmapped;

            cfg_packet_esto.wr_en <= cfg_wr_en;
            cfg_packet_esto.rd_en <= cfg_rd_en;
            cfg_packet_esto.addr <= cfg_addr;
            cfg_packet_esto.wr_data <= cfg_wr_data;
            cfg_packet_esto.rdrs.rd_data <= '0;
            cfg_packet_esto.rdrs.rd_data_valid <= cfg_rd_unmapped;
        end
    end

    // returns from tile 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_rd_data <= '0;
            proc_rd_data_valid <= 1'b0;
            cfg_rd_data <= '0;
            cfg_rd_data_valid <= 1'b0;
        end else begin
            proc_rd_data <= proc_rdrs_wsti.rd_data;
            proc_rd_data_valid <= proc_rdrs_wsti.rd_data_valid;
            cfg_rd_data <= cfg_rdrs_wsti.rd_data;
            cfg_rd_data_valid <= cfg_rdrs_wsti.rd_data_valid;
        end
    end

    // round trip through every tile is fixed
    proc_rd_latency_a: assert property (@(posedge clk) disable iff (reset)
        proc_rd_data_valid |-> $past(proc_rd_en, 2 * NUM_TILES + 2));

    cfg_rd_latency_a: assert property (@(posedge clk) disable iff (reset)
        cfg_rd_data_valid |-> $past(cfg_rd_en, 2 * NUM_TILES + 2));

endmodule

/* logic/global_buffer.sv */
// global buffer top level
`timescale 1ns/1ps

module global_buffer #(
    parameter int NUM_TILES = 4,
    parameter int BANK_ADDR_WIDTH = 6
) (
    input  logic                                 clk,
    input  logic                                 reset,

    // processor port
    input  logic                                 proc_wr_en,
    input  logic [glb_pkg::BANK_STRB_WIDTH-1:0]  proc_wr_strb,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]   proc_wr_addr,
    input  logic [glb_pkg::BANK_DATA_WIDTH-1:0]  proc_wr_data,
    input  logic                                 proc_rd_en,
    input  logic [glb_pkg::GLB_ADDR_WIDTH-1:0]   proc_rd_addr,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0]  proc_rd_data,
    output logic                                 proc_rd_data_valid,

    // configuration port
    input  logic                                 cfg_wr_en,
    input  logic                                 cfg_rd_en,
    input  logic [glb_pkg::CFG_ADDR_WIDTH-1:0]   cfg_addr,
    input  logic [glb_pkg::CFG_DATA_WIDTH-1:0]   cfg_wr_data,
    output logic [glb_pkg::CFG_DATA_WIDTH-1:0]   cfg_rd_data,
    output logic                                 cfg_rd_data_valid
);
    import glb_pkg::*;

    // index k feeds tile k, index NUM_TILES is the east end
    proc_packet_t proc_packet_e [NUM_TILES+1];
    rdrs_packet_t proc_rdrs_w [NUM_TILES+1];
    cfg_packet_t  cfg_packet_e [NUM_TILES+1];
    cfg_rdrs_t    cfg_rdrs_w [NUM_TILES+1];

    glb_dummy_start #(
        .NUM_TILES       (NUM_TILES),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) u_dummy_start (
        .clk                (clk),
        .reset              (reset),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .cfg_wr_en          (cfg_wr_en),
        .cfg_rd_en          (cfg_rd_en),
        .cfg_addr           (cfg_addr),
        .cfg_wr_data        (cfg_wr_data),
        .cfg_rd_data        (cfg_rd_data),
        .cfg_rd_data_valid  (cfg_rd_data_valid),
        .proc_packet_esto   (proc_packet_e[0]),
        .proc_rdrs_wsti     (proc_rdrs_w[0]),
        .cfg_packet_esto    (cfg_packet_e[0]),
        .cfg_rdrs_wsti      (cfg_rdrs_w[0])
    );

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .TILE_ID         (k),
            .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
        ) u_tile (
            .clk              (clk),
            .reset            (reset),
            .proc_packet_wsti (proc_packet_e[k]),
            .proc_packet_esto (proc_packet_e[k+1]),
            .proc_rdrs_esti   (proc_rdrs_w[k+1]),
            .proc_rdrs_wsto   (proc_rdrs_w[k]),
            .cfg_packet_wsti  (cfg_packet_e[k]),
            .cfg_packet_esto  (cfg_packet_e[k+1]),
            .cfg_rdrs_esti    (cfg_rdrs_w[k+1]),
            .cfg_rdrs_wsto    (cfg_rdrs_w[k])
        );
    end

    // east end turns the responses around
    assign proc_rdrs_w[NUM_TILES] = proc_packet_e[NUM_TILES].rdrs;
    assign cfg_rdrs_w[NUM_TILES] = cfg_packet_e[NUM_TILES].rdrs;

endmodule

/* sim/tb_global_buffer.sv */
// global buffer testbench
`timescale 1ns/1ps

module tb_global_buffer;
    import glb_pkg::*;

    localparam int NUM_TILES = 4;
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int NUM_WORDS = 2 ** BANK_ADDR_WIDTH;
    localparam int TILE_BYTES = NUM_WORDS * 8;
    localparam int MEM_BYTES = NUM_TILES * TILE_BYTES;
    localparam int LATENCY = 2 * NUM_TILES + 2;
    localparam int PARTIAL_WORDS = 8;
    // fill, partial, same cycle, tile enable, counters, unmapped
    localparam int TOTAL_OPS = 2 * NUM_TILES * NUM_WORDS + 2 * PARTIAL_WORDS + 2 * NUM_TILES
        + (2 * NUM_TILES + 4) + NUM_TILES + 5;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * 4 + 200;

    logic                       clk;
    logic                       reset;
    logic                       proc_wr_en;
    logic [BANK_STRB_WIDTH-1:0] proc_wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]  proc_wr_addr;
    logic [BANK_DATA_WIDTH-1:0] proc_wr_data;
    logic                       proc_rd_en;
    logic [GLB_ADDR_WIDTH-1:0]  proc_rd_addr;
    logic [BANK_DATA_WIDTH-1:0] proc_rd_data;
    logic                       proc_rd_data_valid;
    logic                       cfg_wr_en;
    logic                       cfg_rd_en;
    logic [CFG_ADDR_WIDTH-1:0]  cfg_addr;
    logic [CFG_DATA_WIDTH-1:0]  cfg_wr_data;
    logic [CFG_DATA_WIDTH-1:0]  cfg_rd_data;
    logic                       cfg_rd_data_valid;

    // reference model
    logic [7:0]                 model_mem [MEM_BYTES];
    logic                       model_tile_en [NUM_TILES];
    logic [CFG_DATA_WIDTH-1:0]  model_wr_count [NUM_TILES];

    // expected responses in issue order
    logic [BANK_DATA_WIDTH-1:0] proc_exp_data [$];
    int                         proc_exp_cycle [$];
    logic [CFG_DATA_WIDTH-1:0]  cfg_exp_data [$];
    int                         cfg_exp_cycle [$];
    logic [BANK_DATA_WIDTH-1:0] proc_exp_word;
    int                         proc_exp_at;
    logic [CFG_DATA_WIDTH-1:0]  cfg_exp_word;
    int                         cfg_exp_at;

    int cycle;
    int checks;
    int value_errors;
    int protocol_errors;
    int seed;

    global_buffer #(
        .NUM_TILES       (NUM_TILES),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) DUT (
        .clk                (clk),
        .reset              (reset),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .cfg_wr_en          (cfg_wr_en),
        .cfg_rd_en          (cfg_rd_en),
        .cfg_addr           (cfg_addr),
        .cfg_wr_data        (cfg_wr_data),
        .cfg_rd_data        (cfg_rd_data),
        .cfg_rd_data_valid  (cfg_rd_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_proc_data(input logic [BANK_DATA_WIDTH-1:0] got,
                                   input logic [BANK_DATA_WIDTH-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cfg_data(input logic [CFG_DATA_WIDTH-1:0] got,
                                  input logic [CFG_DATA_WIDTH-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [GLB_ADDR_WIDTH-1:0] proc_addr(input int tile, input int word);
        return GLB_ADDR_WIDTH'(tile * TILE_BYTES + word * 8);
    endfunction

    function automatic logic [CFG_ADDR_WIDTH-1:0] cfg_reg_addr(input int tile, input int idx);
        return CFG_ADDR_WIDTH'(tile * 256 + idx * 4);
    endfunction

    function automatic logic [BANK_DATA_WIDTH-1:0] predict_proc_read(
        input logic [GLB_ADDR_WIDTH-1:0] addr
    );
        logic [BANK_DATA_WIDTH-1:0] word;
        int                         base;
        int                         b;
        word = '0;
        base = (int'(addr) / 8) * 8;
        if (int'(addr) / TILE_BYTES < NUM_TILES) begin
            for (b = 0; b < 8; b++) begin
                word[b*8 +: 8] = model_mem[base + b];
            end
        end
        return word;
    endfunction

    function automatic void apply_proc_write(input logic [BANK_STRB_WIDTH-1:0] strb,
        input logic [GLB_ADDR_WIDTH-1:0] addr, input logic [BANK_DATA_WIDTH-1:0] data);
        int tile;
        int base;
        int b;
        tile = int'(addr) / TILE_BYTES;
        base = (int'(addr) / 8) * 8;
        // disabled or missing tiles drop the write
        if (tile < NUM_TILES && model_tile_en[tile]) begin
            for (b = 0; b < 8; b++) begin
                if (strb[b]) begin
                    model_mem[base + b] = data[b*8 +: 8];
                end
            end
            model_wr_count[tile] = model_wr_count[tile] + 1;
        end
    endfunction

    function automatic logic [CFG_DATA_WIDTH-1:0] predict_cfg_read(
        input logic [CFG_ADDR_WIDTH-1:0] addr
    );
        int tile;
        int idx;
        tile = int'(addr) / 256;
        idx = (int'(addr) / 4) % 4;
        if (tile >= NUM_TILES) begin
            return '0;
        end else if (idx == CFG_REG_TILE_EN) begin
            return CFG_DATA_WIDTH'(model_tile_en[tile]);
        end else if (idx == CFG_REG_WR_COUNT) begin
            return model_wr_count[tile];
        end
        return '0;
    endfunction

    task automatic issue_proc(input logic wr, input logic [BANK_STRB_WIDTH-1:0] strb,
        input logic [GLB_ADDR_WIDTH-1:0] waddr, input logic [BANK_DATA_WIDTH-1:0] wdata,
        input logic rd, input logic [GLB_ADDR_WIDTH-1:0] raddr);
        @(negedge clk);
        proc_wr_en = wr;
        proc_wr_strb = strb;
        proc_wr_addr = waddr;
        proc_wr_data = wdata;
        proc_rd_en = rd;
        proc_rd_addr = raddr;
        cfg_wr_en = 1'b0;
        cfg_rd_en = 1'b0;
        // a read sees the state before a write of the same cycle
        if (rd) begin
            proc_exp_data.push_back(predict_proc_read(raddr));
            proc_exp_cycle.push_back(cycle + LATENCY);
        end
        if (wr) begin
            apply_proc_write(strb, waddr, wdata);
        end
    endtask

    task automatic issue_cfg(input logic wr, input logic rd,
        input logic [CFG_ADDR_WIDTH-1:0] addr, input logic [CFG_DATA_WIDTH-1:0] wdata);
        int tile;
        @(negedge clk);
        proc_wr_en = 1'b0;
        proc_rd_en = 1'b0;
        cfg_wr_en = wr;
        cfg_rd_en = rd;
        cfg_addr = addr;
        cfg_wr_data = wdata;
        tile = int'(addr) / 256;
        if (rd) begin
            cfg_exp_data.push_back(predict_cfg_read(addr));
            cfg_exp_cycle.push_back(cycle + LATENCY);
        end
        if (wr && tile < NUM_TILES && (int'(addr) / 4) % 4 == CFG_REG_TILE_EN) begin
            model_tile_en[tile] = wdata[0];
        end
    endtask

    task automatic go_idle();
        @(negedge clk);
        proc_wr_en = 1'b0;
        proc_rd_en = 1'b0;
        cfg_wr_en = 1'b0;
        cfg_rd_en = 1'b0;
    endtask

    task automatic wait_for_responses();
        go_idle();
        while (proc_exp_data.size() != 0 || cfg_exp_data.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // outputs are compared at the falling edge where they are stable
    always @(negedge clk) begin
        if (!reset) begin
            if (proc_rd_data_valid) begin
                if (proc_exp_data.size() == 0) begin
                    protocol_errors++;
                    $display("%0t: processor read valid with no read outstanding", $time);
                end else begin
                    proc_exp_word = proc_exp_data.pop_front();
                    proc_exp_at = proc_exp_cycle.pop_front();
                    if (proc_exp_at != cycle) begin
                        protocol_errors++;
                        $display("%0t: processor read answered at cycle %0d instead of %0d",
                                 $time, cycle, proc_exp_at);
                    end
                    check_proc_data(proc_rd_data, proc_exp_word,
                        $sformatf("proc read issued at cycle %0d", proc_exp_at - LATENCY));
                end
            end else if (proc_exp_data.size() != 0 && proc_exp_cycle[0] <= cycle) begin
                proc_exp_at = proc_exp_cycle.pop_front();
                proc_exp_word = proc_exp_data.pop_front();
                protocol_errors++;
                $display("%0t: processor read issued at cycle %0d got no response",
                         $time, proc_exp_at - LATENCY);
            end
            if (cfg_rd_data_valid) begin
                if (cfg_exp_data.size() == 0) begin
                    protocol_errors++;
                    $display("%0t: config read valid with no read outstanding", $time);
                end else begin
                    cfg_exp_word = cfg_exp_data.pop_front();
                    cfg_exp_at = cfg_exp_cycle.pop_front();
                    if (cfg_exp_at != cycle) begin
                        protocol_errors++;
                        $display("%0t: config read answered at cycle %0d instead of %0d",
                                 $time, cycle, cfg_exp_at);
                    end
                    check_cfg_data(cfg_rd_data, cfg_exp_word,
                        $sformatf("cfg read issued at cycle %0d", cfg_exp_at - LATENCY));
                end
            end else if (cfg_exp_data.size() != 0 && cfg_exp_cycle[0] <= cycle) begin
                cfg_exp_at = cfg_exp_cycle.pop_front();
                cfg_exp_word = cfg_exp_data.pop_front();
                protocol_errors++;
                $display("%0t: config read issued at cycle %0d got no response",
                         $time, cfg_exp_at - LATENCY);
            end
        end
    end

    task automatic fill_and_read_all();
        int t;
        int w;
        for (t = 0; t < NUM_TILES; t++) begin
            for (w = 0; w < NUM_WORDS; w++) begin
                issue_proc(1'b1, '1, proc_addr(t, w), {$random(seed), $random(seed)}, 1'b0, '0);
            end
        end
        // back to back reads
        for (t = 0; t < NUM_TILES; t++) begin
            for (w = 0; w < NUM_WORDS; w++) begin
                issue_proc(1'b0, '0, '0, '0, 1'b1, proc_addr(t, w));
            end
        end
        wait_for_responses();
    endtask

    task automatic partial_strobe_writes();
        int i;
        for (i = 0; i < PARTIAL_WORDS; i++) begin
            issue_proc(1'b1, BANK_STRB_WIDTH'($random(seed)),
                       proc_addr(i % NUM_TILES, (i * 7) % NUM_WORDS),
                       {$random(seed), $random(seed)}, 1'b0, '0);
        end
        for (i = 0; i < PARTIAL_WORDS; i++) begin
            issue_proc(1'b0, '0, '0, '0, 1'b1, proc_addr(i % NUM_TILES, (i * 7) % NUM_WORDS));
        end
        wait_for_responses();
    endtask

    task automatic same_cycle_read_write();
        int t;
        for (t = 0; t < NUM_TILES; t++) begin
            issue_proc(1'b1, '1, proc_addr(t, 9), {$random(seed), $random(seed)},
                       1'b1, proc_addr(t, 9));
            issue_proc(1'b0, '0, '0, '0, 1'b1, proc_addr(t, 9));
        end
        wait_for_responses();
    endtask

    task automatic tile_enable_gating();
        int t;
        issue_cfg(1'b1, 1'b0, cfg_reg_addr(2, CFG_REG_TILE_EN), 32'h0);
        for (t = 0; t < NUM_TILES; t++) begin
            issue_proc(1'b1, '1, proc_addr(t, 5), {$random(seed), $random(seed)}, 1'b0, '0);
        end
        for (t = 0; t < NUM_TILES; t++) begin
            issue_proc(1'b0, '0, '0, '0, 1'b1, proc_addr(t, 5));
        end
        issue_cfg(1'b0, 1'b1, cfg_reg_addr(2, CFG_REG_TILE_EN), '0);
        issue_cfg(1'b0, 1'b1, cfg_reg_addr(1, CFG_REG_TILE_EN), '0);
        issue_cfg(1'b1, 1'b0, cfg_reg_addr(2, CFG_REG_TILE_EN), 32'h1);
        wait_for_responses();
    endtask

    task automatic write_counter_readback();
        int t;
        for (t = 0; t < NUM_TILES; t++) begin
            issue_cfg(1'b0, 1'b1, cfg_reg_addr(t, CFG_REG_WR_COUNT), '0);
        end
        wait_for_responses();
    endtask

    task automatic unmapped_reads();
        issue_proc(1'b0, '0, '0, '0, 1'b1, proc_addr(NUM_TILES, 0));
        issue_proc(1'b0, '0, '0, '0, 1'b1, 16'hfff8);
        issue_cfg(1'b0, 1'b1, cfg_reg_addr(0, 2), '0);
        issue_cfg(1'b0, 1'b1, cfg_reg_addr(1, 3), '0);
        issue_cfg(1'b0, 1'b1, cfg_reg_addr(15, CFG_REG_TILE_EN), '0);
        wait_for_responses();
    endtask

    initial begin
        seed = 32'hf1ce_81d6;
        cycle = 0;
        checks = 0;
        value_errors = 0;
        protocol_errors = 0;
        reset = 1'b1;
        proc_wr_en = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en = 1'b0;
        proc_rd_addr = '0;
        cfg_wr_en = 1'b0;
        cfg_rd_en = 1'b0;
        cfg_addr = '0;
        cfg_wr_data = '0;
        for (int t = 0; t < NUM_TILES; t++) begin
            model_tile_en[t] = 1'b1;
            model_wr_count[t] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fill_and_read_all();
        partial_strobe_writes();
        same_cycle_read_write();
        tile_enable_gating();
        write_counter_readback();
        unmapped_reads();

        // catch any late or extra response
        repeat (LATENCY + 2) @(negedge clk);
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
